//--- common/disp_pkg.sv
// disp_pkg: shared widths, scan rate, converter states and segment codes of the readout
package disp_pkg;

	// binary input width
	localparam int DISP_VALUE_BITS = 10;

	// number of packed bcd digits
	localparam int DISP_DIGITS = 4;
	localparam int DISP_BCD_BITS = 4 * DISP_DIGITS;

	// cycles each digit stays selected
	localparam int DISP_SCAN_DIV = 4;
	localparam int DISP_SCAN_CNT_BITS = (DISP_SCAN_DIV > 1) ? $clog2(DISP_SCAN_DIV) : 1;
	localparam logic [DISP_SCAN_CNT_BITS-1:0] DISP_SCAN_LAST =
		DISP_SCAN_CNT_BITS'(DISP_SCAN_DIV - 1);

	// digit index of the scanner
	localparam int DISP_IDX_BITS = (DISP_DIGITS > 1) ? $clog2(DISP_DIGITS) : 1;
	localparam logic [DISP_IDX_BITS-1:0] DISP_IDX_LAST = DISP_IDX_BITS'(DISP_DIGITS - 1);

	// double-dabble sequencer states
	typedef enum logic [2:0] {
		idle,
		clear,
		shift,
		add,
		next_bit
	} conv_state_t;

	// bit 0 is segment a up to bit 6 segment g and a set bit is lit
	typedef logic [6:0] seg_code_t;

	localparam seg_code_t SEG_BLANK = 7'h00;

	// patterns for decimal digits 0 to 9
	localparam seg_code_t SEG_DIGIT [10] = '{
		7'h3f, 7'h06, 7'h5b, 7'h4f, 7'h66,
		7'h6d, 7'h7d, 7'h07, 7'h7f, 7'h6f
	};

endpackage

//--- bcd/bcd_convert.sv
// bcd_convert: sequential shift-and-add-3 converter from a binary value to packed bcd digits
module bcd_convert #(
	parameter int in_bits    = disp_pkg::DISP_VALUE_BITS,
	parameter int num_digits = disp_pkg::DISP_DIGITS
) (
	input  logic                    in_clk,
	input  logic                    in_rst,
	input  logic                    start,
	input  logic [in_bits-1:0]      num,
	output logic [4*num_digits-1:0] bcd,
	output logic                    finished,
	output logic                    done
);

	localparam int bcd_w = 4 * num_digits;
	localparam int idx_w = (in_bits > 1) ? $clog2(in_bits) : 1;
	localparam int dig_w = (num_digits > 1) ? $clog2(num_digits) : 1;

	// msb first, top digit first
	localparam logic [idx_w-1:0] bit_first = idx_w'(in_bits - 1);
	localparam logic [dig_w-1:0] dig_first = dig_w'(num_digits - 1);

	disp_pkg::conv_state_t state;
	disp_pkg::conv_state_t state_next;

	logic [bcd_w-1:0]   acc;
	logic [bcd_w-1:0]   acc_next;
	logic [in_bits-1:0] num_q;
	logic [idx_w-1:0]   bit_idx;
	logic [idx_w-1:0]   bit_idx_next;
	logic [dig_w-1:0]   dig_idx;
	logic [dig_w-1:0]   dig_idx_next;
	logic [3:0]         cur_digit;
	logic               accept;
	logic               done_q;

	assign bcd      = acc;
	assign finished = (state == disp_pkg::idle);
	assign done     = done_q;

	// a start only counts while idle, a busy start is dropped
	assign accept = (state == disp_pkg::idle) && start;

	// digit under test in the add phase
	assign cur_digit = acc[dig_idx*4 +: 4];

	always_ff @(posedge in_clk or posedge in_rst) begin
		if (in_rst) begin
			state   <= disp_pkg::idle;
			acc     <= '0;
			bit_idx <= bit_first;
			dig_idx <= dig_first;
			done_q  <= 1'b0;
		end else begin
			state   <= state_next;
			acc     <= acc_next;
			bit_idx <= bit_idx_next;
			dig_idx <= dig_idx_next;
			// last shift is the one that returns to idle
			done_q  <= (state == disp_pkg::shift) && (bit_idx == '0);
		end
	end

	// input copy, held for the whole conversion
	always_ff @(posedge in_clk) begin
		if (accept) begin
			num_q <= num;
		end
	end

	always_comb begin
		state_next   = state;
		acc_next     = acc;
		bit_idx_next = bit_idx;
		dig_idx_next = dig_idx;

		unique case (state)
			disp_pkg::idle: begin
				if (start) begin
					// old result goes away with the new start
					acc_next   = '0;
					state_next = disp_pkg::clear;
				end
			end

			disp_pkg::clear: begin
				acc_next     = '0;
				bit_idx_next = bit_first;
				dig_idx_next = dig_first;
				state_next   = disp_pkg::shift;
			end

			disp_pkg::shift: begin
				acc_next = {acc[bcd_w-2:0], num_q[bit_idx]};
				// no correction after the lsb
				if (bit_idx != '0) begin
					state_next = disp_pkg::add;
				end else begin
					state_next = disp_pkg::idle;
				end
			end

			disp_pkg::add: begin
				// digit of 5 or more gets 3, no carry into the next nibble
				if (cur_digit >= 4'd5) begin
					acc_next[dig_idx*4 +: 4] = cur_digit + 4'd3;
				end
				if (dig_idx != '0) begin
					dig_idx_next = dig_idx - 1'b1;
				end else begin
					dig_idx_next = dig_first;
					state_next   = disp_pkg::next_bit;
				end
			end

			disp_pkg::next_bit: begin
				bit_idx_next = bit_idx - 1'b1;
				state_next   = disp_pkg::shift;
			end

			default: begin
				state_next = disp_pkg::idle;
			end
		endcase
	end

endmodule

//--- src/digit_scan.sv
// digit_scan: latches finished bcd results and multiplexes them onto a seven-segment display
module digit_scan (
	input  logic                                in_clk,
	input  logic                                in_rst,
	input  logic                                load,
	input  logic [disp_pkg::DISP_BCD_BITS-1:0]  bcd,
	output disp_pkg::seg_code_t                 seg,
	output logic [disp_pkg::DISP_DIGITS-1:0]    digit_sel
);

	logic [disp_pkg::DISP_BCD_BITS-1:0]      disp_val;
	logic [disp_pkg::DISP_SCAN_CNT_BITS-1:0] scan_cnt;
	logic [disp_pkg::DISP_IDX_BITS-1:0]      idx;
	logic [disp_pkg::DISP_DIGITS-1:0]        zero_from;
	logic [3:0]                              nibble;
	logic                                    blank;

	// value on display is only replaced by a finished result
	always_ff @(posedge in_clk or posedge in_rst) begin
		if (in_rst) begin
			disp_val <= '0;
		end else if (load) begin
			disp_val <= bcd;
		end
	end

	// prescaler and digit index
	always_ff @(posedge in_clk or posedge in_rst) begin
		if (in_rst) begin
			scan_cnt <= '0;
			idx      <= '0;
		end else if (scan_cnt == disp_pkg::DISP_SCAN_LAST) begin
			scan_cnt <= '0;
			if (idx == disp_pkg::DISP_IDX_LAST) begin
				idx <= '0;
			end else begin
				idx <= idx + 1'b1;
			end
		end else begin
			scan_cnt <= scan_cnt + 1'b1;
		end
	end

	// set when digit i and every digit above it are zero
	always_comb begin
		zero_from[disp_pkg::DISP_DIGITS-1] =
			(disp_val[disp_pkg::DISP_BCD_BITS-1 -: 4] == 4'd0);
		for (int i = disp_pkg::DISP_DIGITS - 2; i >= 0; i--) begin
			zero_from[i] = (disp_val[i*4 +: 4] == 4'd0) && zero_from[i+1];
		end
	end

	assign nibble = disp_val[idx*4 +: 4];

	// leading zeros go dark, digit 0 always shows
	assign blank = (idx != '0) && zero_from[idx];

	always_comb begin
		if (blank || (nibble > 4'd9)) begin
			seg = disp_pkg::SEG_BLANK;
		end else begin
			seg = disp_pkg::SEG_DIGIT[nibble];
		end
	end

	// one-hot select of the current digit
	always_comb begin
		digit_sel      = '0;
		digit_sel[idx] = 1'b1;
	end

endmodule

//--- src/disp_top.sv
// disp_top: decimal readout, binary to bcd conversion feeding a multiplexed segment display
module disp_top (
	input  logic                                 in_clk,
	input  logic                                 in_rst,
	input  logic                                 load,
	input  logic [disp_pkg::DISP_VALUE_BITS-1:0] value,
	output logic [disp_pkg::DISP_BCD_BITS-1:0]   bcd,
	output logic                                 ready,
	output disp_pkg::seg_code_t                  seg,
	output logic [disp_pkg::DISP_DIGITS-1:0]     digit_sel
);

	// one-cycle pulse at the end of a conversion
	logic conv_done;

	bcd_convert u_convert (
		.in_clk   (in_clk),
		.in_rst   (in_rst),
		.start    (load),
		.num      (value),
		.bcd      (bcd),
		.finished (ready),
		.done     (conv_done)
	);

	// display picks up the result right after done
	digit_scan u_scan (
		.in_clk    (in_clk),
		.in_rst    (in_rst),
		.load      (conv_done),
		.bcd       (bcd),
		.seg       (seg),
		.digit_sel (digit_sel)
	);

endmodule

//--- tb/disp_sva.sv
// disp_sva: concurrent checks on conversion timing and digit select of the readout
module disp_sva (
	input logic                             in_clk,
	input logic                             in_rst,
	input logic                             load,
	input logic                             ready,
	input logic                             conv_done,
	input disp_pkg::conv_state_t            state,
	input logic [disp_pkg::DISP_DIGITS-1:0] digit_sel
);
	timeunit 1ns;
	timeprecision 1ps;

	// ready is low for this many sampled cycles of one conversion
	localparam int LOW_CYCLES = 56;

	logic       accept;
	logic [6:0] low_cnt;

	assign accept = load && (state == disp_pkg::idle);

	// saturating length of the current stretch of ready low
	always_ff @(posedge in_clk or posedge in_rst) begin
		if (in_rst) begin
			low_cnt <= '0;
		end else if (ready) begin
			low_cnt <= '0;
		end else if (low_cnt != '1) begin
			low_cnt <= low_cnt + 1'b1;
		end
	end

	onehot_sel: assert property (@(posedge in_clk) disable iff (in_rst)
		$onehot(digit_sel))
		else $error("digit_sel is not one-hot: %b", digit_sel);

	load_drops_ready: assert property (@(posedge in_clk) disable iff (in_rst)
		load && ready |=> !ready)
		else $error("ready still high after an accepted load");

	ready_latency: assert property (@(posedge in_clk) disable iff (in_rst)
		accept |=> !ready [*LOW_CYCLES] ##1 ready)
		else $error("ready did not rise 57 cycles after an accepted load");

	done_after_full: assert property (@(posedge in_clk) disable iff (in_rst)
		conv_done |-> low_cnt >= LOW_CYCLES)
		else $error("done after only %0d cycles of ready low", low_cnt);

endmodule

bind disp_top disp_sva sva (
	.in_clk    (in_clk),
	.in_rst    (in_rst),
	.load      (load),
	.ready     (ready),
	.conv_done (conv_done),
	.state     (u_convert.state),
	.digit_sel (digit_sel)
);

//--- tb/disp_tb.sv
// disp_tb: directed testbench for the readout, checking latency, bcd results and the digit scan
module disp_tb;
	timeunit 1ns;
	timeprecision 1ps;

	// timeout covers 35 conversions of about 60 cycles twice over plus reset and scans
	localparam int CONV_CYCLES = 60;
	localparam int NUM_CONV = 35;
	localparam int TIMEOUT_CYCLES = 2 * NUM_CONV * CONV_CYCLES + 800;
	localparam int LATENCY = 57;
	localparam int DIV = disp_pkg::DISP_SCAN_DIV;
	localparam int DIGITS = disp_pkg::DISP_DIGITS;
	localparam int SCAN_LEN = DIGITS * DIV;
	localparam int DIRECTED [8] = '{0, 9, 10, 99, 100, 999, 1000, 1023};

	// segment patterns in bit order gfedcba
	localparam disp_pkg::seg_code_t SEG_REF [10] = '{
		7'b0111111, 7'b0000110, 7'b1011011, 7'b1001111, 7'b1100110,
		7'b1101101, 7'b1111101, 7'b0000111, 7'b1111111, 7'b1101111
	};

	logic                                 in_clk;
	logic                                 in_rst;
	logic                                 load;
	logic [disp_pkg::DISP_VALUE_BITS-1:0] value;
	logic [disp_pkg::DISP_BCD_BITS-1:0]   bcd;
	logic                                 ready;
	disp_pkg::seg_code_t                  seg;
	logic [DIGITS-1:0]                    digit_sel;

	int n_checks;
	int n_errors;
	int cycle_count;
	int scan_edges;

	disp_top dut (
		.in_clk    (in_clk),
		.in_rst    (in_rst),
		.load      (load),
		.value     (value),
		.bcd       (bcd),
		.ready     (ready),
		.seg       (seg),
		.digit_sel (digit_sel)
	);

	initial begin
		in_clk = 1'b0;
	end

	always #10 in_clk = ~in_clk;

	// edges since reset release give the expected scan position
	always @(posedge in_clk) begin
		if (in_rst) begin
			scan_edges <= 0;
		end else begin
			scan_edges <= scan_edges + 1;
		end
	end

	function automatic logic [disp_pkg::DISP_BCD_BITS-1:0] expected_bcd(input int v);
		logic [disp_pkg::DISP_BCD_BITS-1:0] res;
		int rest;
		res = '0;
		rest = v;
		for (int d = 0; d < DIGITS; d++) begin
			res[d*4 +: 4] = 4'(rest % 10);
			rest = rest / 10;
		end
		return res;
	endfunction

	// leading zeros go dark and the lowest digit stays lit
	function automatic disp_pkg::seg_code_t expected_seg(input int v, input int idx);
		int rest;
		rest = v;
		for (int d = 0; d < idx; d++) begin
			rest = rest / 10;
		end
		if (idx != 0 && rest == 0) begin
			return 7'b0000000;
		end
		return SEG_REF[rest % 10];
	endfunction

	task automatic check_bcd(input string name, input logic [disp_pkg::DISP_BCD_BITS-1:0] exp,
			input logic [disp_pkg::DISP_BCD_BITS-1:0] act);
		n_checks++;
		if (act !== exp) begin
			n_errors++;
			$display("FAIL %0t ns %s expected %h got %h", $time, name, exp, act);
		end
	endtask

	task automatic check_seg(input string name, input disp_pkg::seg_code_t exp,
			input disp_pkg::seg_code_t act);
		n_checks++;
		if (act !== exp) begin
			n_errors++;
			$display("FAIL %0t ns %s expected %b got %b", $time, name, exp, act);
		end
	endtask

	task automatic check_sel(input string name, input logic [DIGITS-1:0] exp,
			input logic [DIGITS-1:0] act);
		n_checks++;
		if (act !== exp) begin
			n_errors++;
			$display("FAIL %0t ns %s expected %b got %b", $time, name, exp, act);
		end
	endtask

	task automatic check_flag(input string name, input logic exp, input logic act);
		n_checks++;
		if (act !== exp) begin
			n_errors++;
			$display("FAIL %0t ns %s expected %b got %b", $time, name, exp, act);
		end
	endtask

	task automatic check_int(input string name, input int exp, input int act);
		n_checks++;
		if (act !== exp) begin
			n_errors++;
			$display("FAIL %0t ns %s expected %0d got %0d", $time, name, exp, act);
		end
	endtask

	task automatic report_test(input string name, input int err_before);
		$display("test %s done, %0d errors", name, n_errors - err_before);
	endtask

	// one load strobe with an optional second strobe while busy
	// returns at the negedge with ready high
	task automatic run_conversion(input int v, input int busy_at, input int busy_val);
		int edges;
		@(posedge in_clk);
		load <= 1'b1;
		value <= v[disp_pkg::DISP_VALUE_BITS-1:0];
		// accepting edge
		@(posedge in_clk);
		load <= 1'b0;
		edges = 1;
		@(negedge in_clk);
		check_flag("ready", 1'b0, ready);
		while (ready !== 1'b1 && edges < LATENCY + 20) begin
			@(posedge in_clk);
			edges++;
			load <= (edges == busy_at);
			if (edges == busy_at) begin
				value <= busy_val[disp_pkg::DISP_VALUE_BITS-1:0];
			end
			@(negedge in_clk);
		end
		check_int("latency", LATENCY, edges);
		check_bcd("bcd", expected_bcd(v), bcd);
	endtask

	task automatic test_reset();
		int err_before;
		err_before = n_errors;
		@(negedge in_clk);
		check_flag("ready", 1'b1, ready);
		check_bcd("bcd", '0, bcd);
		check_sel("digit_sel", 4'b0001, digit_sel);
		check_seg("seg", expected_seg(0, 0), seg);
		report_test("reset", err_before);
	endtask

	task automatic test_directed();
		int err_before;
		err_before = n_errors;
		foreach (DIRECTED[i]) begin
			run_conversion(DIRECTED[i], 0, 0);
		end
		report_test("directed", err_before);
	endtask

	task automatic test_random();
		int err_before;
		err_before = n_errors;
		repeat (20) begin
			run_conversion($urandom % 1024, 0, 0);
		end
		report_test("random", err_before);
	endtask

	// second strobe 10 cycles into the first conversion must be dropped
	task automatic test_busy_ignore();
		int err_before;
		err_before = n_errors;
		run_conversion(321, 10, 654);
		report_test("busy_ignore", err_before);
	endtask

	task automatic scan_value(input int v);
		int idx;
		logic [DIGITS-1:0] exp_sel;
		run_conversion(v, 0, 0);
		// display latches on the edge after done
		@(posedge in_clk);
		repeat (SCAN_LEN) begin
			@(negedge in_clk);
			idx = (scan_edges / DIV) % DIGITS;
			exp_sel = '0;
			exp_sel[idx] = 1'b1;
			check_sel("digit_sel", exp_sel, digit_sel);
			check_seg("seg", expected_seg(v, idx), seg);
		end
	endtask

	task automatic test_display();
		int err_before;
		err_before = n_errors;
		scan_value(507);
		scan_value(42);
		report_test("display", err_before);
	endtask

	initial begin
		cycle_count = 0;
		while (cycle_count < TIMEOUT_CYCLES) begin
			@(posedge in_clk);
			cycle_count++;
		end
		$display("timeout, the run did not finish within %0d cycles", TIMEOUT_CYCLES);
		$display("FAIL: see errors above");
		$finish;
	end

	initial begin
		void'($urandom(11676));
		n_checks = 0;
		n_errors = 0;
		in_rst = 1'b1;
		load = 1'b0;
		value = '0;
		repeat (8) @(posedge in_clk);
		in_rst <= 1'b0;
		test_reset();
		test_directed();
		test_random();
		test_busy_ignore();
		test_display();
		$display("summary: %0d checks, %0d errors", n_checks, n_errors);
		if (n_errors == 0) begin
			$display("PASS: all tests");
		end else begin
			$display("FAIL: see errors above");
		end
		$finish;
	end

endmodule

//--- disp_top.f
common/disp_pkg.sv
bcd/bcd_convert.sv
src/digit_scan.sv
src/disp_top.sv
tb/disp_sva.sv
tb/disp_tb.sv
